// File: hw/fmac_norm_pkg.sv
// FMA normalization back end: shared format widths, rounding modes and NaN encoding

package fmac_norm_pkg;

  ////////////////////////////////////////
  // Format widths
  ////////////////////////////////////////

  localparam int EXP_W  = 8;               // Single-precision exponent
  localparam int MANT_W = 23;              // Stored fraction, hidden bit excluded

  // Unnormalized adder sum: product (2x) plus addend (1x) plus carry/guard room
  localparam int SUM_W  = 3*MANT_W + 5;

  // Leading-one count must be able to point anywhere inside the sum
  localparam int LZ_W   = $clog2(SUM_W);

  ////////////////////////////////////////
  // Rounding modes
  ////////////////////////////////////////

  // Codes 4..7 are treated as "never round up"
  typedef enum logic [2:0] {
    rnd_rne = 3'd0,                        // Nearest, ties to even
    rnd_rtz = 3'd1,                        // Toward zero
    rnd_rdn = 3'd2,                        // Toward minus infinity
    rnd_rup = 3'd3                         // Toward plus infinity
  } rnd_mode_t;

  ////////////////////////////////////////
  // Special encodings
  ////////////////////////////////////////

  // Canonical quiet NaN fraction, only the top stored bit set
  localparam logic [MANT_W-1:0] MANT_QNAN = {1'b1, {(MANT_W-1){1'b0}}};

endpackage

// File: hw/fmac_norm_top.sv
// FMA normalization and rounding back end, two-stage streaming pipeline
`timescale 1ns/100ps

module fmac_norm_top
  import fmac_norm_pkg::*;
#(
  parameter int EXP_W  = fmac_norm_pkg::EXP_W,
  parameter int MANT_W = fmac_norm_pkg::MANT_W
)
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  logic [SUM_W-1:0]        mant_in,          // Unnormalized adder sum
  input  logic signed [EXP_W+1:0] exp_in,
  input  logic                    sign_in,
  input  logic [LZ_W-1:0]         lead_one,         // From the leading-one predictor
  input  logic                    no_one,
  input  logic                    sub_op,
  input  rnd_mode_t               rnd_mode,
  input  logic                    inf_a,
  input  logic                    inf_b,
  input  logic                    inf_c,
  input  logic                    zero_a,
  input  logic                    zero_b,
  input  logic                    zero_c,
  input  logic                    nan_a,
  input  logic                    nan_b,
  input  logic                    nan_c,
  input  logic                    sticky_shift_in,
  input  logic                    sticky_minus_in,
  output logic                    out_valid,
  output logic [MANT_W-1:0]       mant_res,
  output logic [EXP_W-1:0]        exp_res,
  output logic                    sign_res,
  output logic                    of_flag,
  output logic                    uf_flag,
  output logic                    inexact,
  output logic                    invalid
);

  // Shifter to classifier, combinational
  logic [SUM_W-1:0] mant_lsh;
  logic [EXP_W+1:0] exp_post;
  logic [EXP_W+1:0] exp_post_m1;
  logic [SUM_W+1:0] mant_rsh;
  logic             exp_too_small;
  logic             sticky;

  // Classifier to rounder, registered
  logic             norm_valid;
  logic [MANT_W:0]  norm_mant;
  logic [EXP_W-1:0] norm_exp;
  logic [1:0]       norm_guard;
  logic             norm_sticky;
  logic             norm_sign;
  logic             norm_of;
  logic             norm_uf;
  logic             norm_invalid;
  rnd_mode_t        norm_rnd;

  ////////////////////////////////////////
  // Stages
  ////////////////////////////////////////

  norm_shift #(.EXP_W(EXP_W), .MANT_W(MANT_W)) u_shift (
    .mant_in, .exp_in, .lead_one, .sticky_shift_in, .sticky_minus_in,
    .mant_lsh, .exp_post, .exp_post_m1, .mant_rsh, .exp_too_small, .sticky
  );

  norm_classify #(.EXP_W(EXP_W), .MANT_W(MANT_W)) u_classify (
    .clk, .rst_n, .in_valid, .rnd_mode, .sign_in, .no_one, .sub_op,
    .inf_a, .inf_b, .inf_c, .zero_a, .zero_b, .zero_c, .nan_a, .nan_b, .nan_c,
    .exp_neg (exp_in[EXP_W+1]),       // Sign bit selects the right-shift path
    .mant_lsh, .exp_post, .exp_post_m1, .mant_rsh, .exp_too_small, .sticky,
    .norm_valid, .norm_mant, .norm_exp, .norm_guard, .norm_sticky,
    .norm_sign, .norm_of, .norm_uf, .norm_invalid, .norm_rnd
  );

  round_unit #(.EXP_W(EXP_W), .MANT_W(MANT_W)) u_round (
    .clk, .rst_n,
    .norm_valid, .norm_mant, .norm_exp, .norm_guard, .norm_sticky,
    .norm_sign, .norm_of, .norm_uf, .norm_invalid, .norm_rnd,
    .out_valid, .mant_res, .exp_res, .sign_res,
    .of_flag, .uf_flag, .inexact, .invalid
  );

endmodule

// File: hw/norm_classify.sv
// Special-case resolution of the normalized sum and first pipeline register
`timescale 1ns/100ps

module norm_classify
  import fmac_norm_pkg::*;
#(
  parameter int EXP_W  = fmac_norm_pkg::EXP_W,
  parameter int MANT_W = fmac_norm_pkg::MANT_W
)
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  rnd_mode_t        rnd_mode,
  input  logic             sign_in,
  input  logic             no_one,          // Sum is exactly zero
  input  logic             sub_op,
  input  logic             inf_a,
  input  logic             inf_b,
  input  logic             inf_c,
  input  logic             zero_a,
  input  logic             zero_b,
  input  logic             zero_c,
  input  logic             nan_a,
  input  logic             nan_b,
  input  logic             nan_c,
  input  logic             exp_neg,         // Sign of the incoming exponent
  input  logic [SUM_W-1:0] mant_lsh,
  input  logic [EXP_W+1:0] exp_post,
  input  logic [EXP_W+1:0] exp_post_m1,
  input  logic [SUM_W+1:0] mant_rsh,
  input  logic             exp_too_small,
  input  logic             sticky,
  output logic             norm_valid,
  output logic [MANT_W:0]  norm_mant,
  output logic [EXP_W-1:0] norm_exp,
  output logic [1:0]       norm_guard,
  output logic             norm_sticky,
  output logic             norm_sign,
  output logic             norm_of,
  output logic             norm_uf,
  output logic             norm_invalid,
  output rnd_mode_t        norm_rnd
);

  localparam logic [EXP_W-1:0] EXP_ONES = '1;

  logic             inv;
  logic             any_inf;
  logic             exp_ovf;
  logic [MANT_W:0]  sel_mant;
  logic [EXP_W-1:0] sel_exp;
  logic [1:0]       sel_guard;
  logic             sel_sticky;
  logic             sel_sign;
  logic             sel_of;
  logic             sel_uf;

  ////////////////////////////////////////
  // Operand classes
  ////////////////////////////////////////

  // NaN in, 0 x inf, or inf - inf
  assign inv = nan_a | nan_b | nan_c | (zero_b & inf_c) | (zero_c & inf_b) |
               (sub_op & inf_a & (inf_b | inf_c));
  // The adder already folded a zero addend into the sum
  assign any_inf = inf_a | inf_b | inf_c;

  // 255 with the leading bit in place, or past the exponent range
  assign exp_ovf = exp_post[EXP_W] | exp_post[EXP_W+1] |
                   ((exp_post[EXP_W-1:0] == EXP_ONES) & mant_lsh[SUM_W-1]);

  ////////////////////////////////////////
  // Prioritized result selection
  ////////////////////////////////////////

  always_comb
  begin
    sel_mant   = '0;
    sel_exp    = '0;
    sel_guard  = 2'b00;
    sel_sticky = 1'b0;
    sel_sign   = sign_in;
    sel_of     = 1'b0;
    sel_uf     = 1'b0;
    if (inv)
    begin
      sel_mant = {1'b0, MANT_QNAN};
      sel_exp  = EXP_ONES;
      sel_sign = 1'b0;                     // Positive quiet NaN
    end
    else if (any_inf)
    begin
      sel_exp = EXP_ONES;
      sel_of  = 1'b1;
    end
    else if (no_one)
    begin
      // Signed zero from the defaults
    end
    else if (exp_neg && exp_too_small)
      sel_uf = 1'b1;                       // Flushed to zero
    else if (exp_neg)
    begin
      sel_mant   = mant_rsh[SUM_W+1 -: MANT_W+1];   // Top bit is always zero here
      sel_guard  = mant_rsh[SUM_W-MANT_W -: 2];
      sel_sticky = sticky;
      sel_uf     = 1'b1;
    end
    else if (exp_ovf)
    begin
      sel_exp = EXP_ONES;
      sel_of  = 1'b1;
    end
    else if (exp_post == '0)
    begin
      sel_mant   = {1'b0, mant_lsh[SUM_W-1 -: MANT_W]};   // Exponent zero takes one place right
      sel_guard  = mant_lsh[SUM_W-MANT_W-1 -: 2];
      sel_sticky = sticky;
      sel_uf     = 1'b1;
    end
    else if (exp_post == 1 && !mant_lsh[SUM_W-1])
    begin
      sel_mant   = mant_lsh[SUM_W-1 -: MANT_W+1];
      sel_guard  = mant_lsh[SUM_W-MANT_W-2 -: 2];
      sel_sticky = sticky;
      sel_uf     = 1'b1;
    end
    else if (!mant_lsh[SUM_W-1])
    begin
      sel_mant   = mant_lsh[SUM_W-2 -: MANT_W+1];     // Leading one at 0X.XX
      sel_exp    = exp_post_m1[EXP_W-1:0];
      sel_guard  = mant_lsh[SUM_W-MANT_W-3 -: 2];
      sel_sticky = sticky;
    end
    else
    begin
      sel_mant   = mant_lsh[SUM_W-1 -: MANT_W+1];     // Leading one at 1X.XX
      sel_exp    = exp_post[EXP_W-1:0];
      sel_guard  = mant_lsh[SUM_W-MANT_W-2 -: 2];
      sel_sticky = sticky;
    end
  end

  ////////////////////////////////////////
  // Stage-one register
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      norm_valid <= 1'b0;
    else
      norm_valid <= in_valid;
  end

  // Payload loads only with a valid item
  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      norm_mant    <= sel_mant;
      norm_exp     <= sel_exp;
      norm_guard   <= sel_guard;
      norm_sticky  <= sel_sticky;
      norm_sign    <= sel_sign;
      norm_of      <= sel_of;
      norm_uf      <= sel_uf;
      norm_invalid <= inv;
      norm_rnd     <= rnd_mode;
    end
  end

endmodule

// File: hw/norm_shift.sv
// Normalization shifter: leading-one exponent correction, denormal right shift, sticky bit
`timescale 1ns/100ps

module norm_shift
  import fmac_norm_pkg::*;
#(
  parameter int EXP_W  = fmac_norm_pkg::EXP_W,
  parameter int MANT_W = fmac_norm_pkg::MANT_W
)
(
  input  logic [SUM_W-1:0]        mant_in,
  input  logic signed [EXP_W+1:0] exp_in,
  input  logic [LZ_W-1:0]         lead_one,
  input  logic                    sticky_shift_in,   // Bits lost in the alignment shifter
  input  logic                    sticky_minus_in,   // Bits lost in the subtraction
  output logic [SUM_W-1:0]        mant_lsh,
  output logic [EXP_W+1:0]        exp_post,
  output logic [EXP_W+1:0]        exp_post_m1,
  output logic [SUM_W+1:0]        mant_rsh,
  output logic                    exp_too_small,
  output logic                    sticky
);

  localparam int RS_LIMIT = SUM_W;   // Beyond this every sum bit lands below the guard bits

  logic [LZ_W-1:0]         lead_eff;
  logic signed [EXP_W+1:0] lead_ext;
  logic                    exp_pos;  // Strictly positive exponent
  logic                    exp_gt;   // Room for the full leading-one shift
  logic [EXP_W:0]          lsh_amt;
  logic [EXP_W+1:0]        rsh_amt;
  logic [2*SUM_W+1:0]      rsh_wide; // Extra low half catches everything shifted out
  logic                    low_bits;

  ////////////////////////////////////////
  // Left shift by the leading-one count
  ////////////////////////////////////////

  // Carry into the top bit means the sum is already normalized
  assign lead_eff = mant_in[SUM_W-1] ? '0 : lead_one;
  assign lead_ext = signed'({{(EXP_W+2-LZ_W){1'b0}}, lead_eff});

  assign exp_pos = ~exp_in[EXP_W+1] & (exp_in != '0);
  assign exp_gt  = exp_in > lead_ext;

  always_comb
  begin
    if (!exp_pos)
    begin
      lsh_amt  = '0;                     // Zero or negative, handled elsewhere
      exp_post = '0;
    end
    else if (exp_gt)
    begin
      lsh_amt  = lead_ext[EXP_W:0];
      exp_post = exp_in - lead_ext;
    end
    else
    begin
      // Not enough exponent left, stop at exponent one and go denormal
      lsh_amt  = exp_in[EXP_W:0] - 1'b1;
      exp_post = {{(EXP_W+1){1'b0}}, 1'b1};
    end
  end

  assign mant_lsh    = mant_in << lsh_amt;
  assign exp_post_m1 = exp_post - 1'b1;  // For a leading one that sits one place low

  ////////////////////////////////////////
  // Right shift for negative exponents
  ////////////////////////////////////////

  assign rsh_amt       = ~exp_in + 2'd2;   // |exp| + 1
  assign exp_too_small = rsh_amt > RS_LIMIT;

  assign rsh_wide = {mant_in, 2'b00, {SUM_W{1'b0}}} >> rsh_amt;
  assign mant_rsh = rsh_wide[2*SUM_W+1:SUM_W];  // Two extra LSBs feed the guard bits

  ////////////////////////////////////////
  // Sticky
  ////////////////////////////////////////

  // Window below the guard bits follows the result cases in norm_classify
  always_comb
  begin
    if (exp_in[EXP_W+1])
      low_bits = |rsh_wide[SUM_W+2*MANT_W+3:0];
    else if (exp_post == '0)
      low_bits = |mant_lsh[2*MANT_W+2:0];      // Result taken one place higher
    else if (mant_lsh[SUM_W-1] || exp_post == 1)
      low_bits = |mant_lsh[2*MANT_W+1:0];
    else
      low_bits = |mant_lsh[2*MANT_W:0];        // 0X.XX, window one place lower
  end

  assign sticky = low_bits | sticky_shift_in | sticky_minus_in;

endmodule

// File: hw/round_unit.sv
// Rounding, renormalization on carry and the output register
`timescale 1ns/100ps

module round_unit
  import fmac_norm_pkg::*;
#(
  parameter int EXP_W  = fmac_norm_pkg::EXP_W,
  parameter int MANT_W = fmac_norm_pkg::MANT_W
)
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              norm_valid,
  input  logic [MANT_W:0]   norm_mant,     // Hidden bit plus fraction
  input  logic [EXP_W-1:0]  norm_exp,
  input  logic [1:0]        norm_guard,    // Round bit, then one more
  input  logic              norm_sticky,
  input  logic              norm_sign,
  input  logic              norm_of,
  input  logic              norm_uf,
  input  logic              norm_invalid,
  input  rnd_mode_t         norm_rnd,
  output logic              out_valid,
  output logic [MANT_W-1:0] mant_res,
  output logic [EXP_W-1:0]  exp_res,
  output logic              sign_res,
  output logic              of_flag,
  output logic              uf_flag,
  output logic              inexact,
  output logic              invalid
);

  localparam logic [EXP_W-1:0] EXP_MAX = {{(EXP_W-1){1'b1}}, 1'b0};  // Largest finite

  logic              lost;          // Any nonzero bit below the LSB
  logic              round_up;
  logic [MANT_W+1:0] mant_sum;
  logic              carry;
  logic              dn_promote;    // Denormal rounded into the normal range
  logic [MANT_W-1:0] mant_rnd;
  logic [EXP_W-1:0]  exp_rnd;

  ////////////////////////////////////////
  // Round-up decision
  ////////////////////////////////////////

  assign lost = |norm_guard | norm_sticky;

  always_comb
  begin
    case (norm_rnd)
      rnd_rne: round_up = norm_guard[1] & (norm_guard[0] | norm_sticky | norm_mant[0]);
      rnd_rtz: round_up = 1'b0;
      rnd_rup: round_up = lost & ~norm_sign;
      rnd_rdn: round_up = lost & norm_sign;
      default: round_up = 1'b0;       // Unused codes truncate
    endcase
  end

  ////////////////////////////////////////
  // Increment and renormalize
  ////////////////////////////////////////

  assign mant_sum   = {1'b0, norm_mant} + round_up;
  assign carry      = mant_sum[MANT_W+1];              // 1.11..1 + 1 = 10.00..0
  assign dn_promote = (norm_exp == '0) & mant_sum[MANT_W];
  assign mant_rnd   = carry ? mant_sum[MANT_W:1] : mant_sum[MANT_W-1:0];
  assign exp_rnd    = norm_exp + (carry | dn_promote);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      out_valid <= 1'b0;
    else
      out_valid <= norm_valid;
  end

  always_ff @(posedge clk)
  begin
    if (norm_valid)
    begin
      mant_res <= mant_rnd;
      exp_res  <= exp_rnd;
      sign_res <= norm_sign;
      of_flag  <= norm_of | (carry & (norm_exp == EXP_MAX));  // Rounded up into infinity
      uf_flag  <= norm_uf;
      inexact  <= lost;
      invalid  <= norm_invalid;
    end
  end

endmodule

// File: sim.f
hw/fmac_norm_pkg.sv
hw/norm_shift.sv
hw/norm_classify.sv
hw/round_unit.sv
hw/fmac_norm_top.sv
+incdir+tb
tb/fmac_norm_chk.sv
tb/tb_fmac_norm.sv

// File: tb/fmac_norm_chk.sv
// Protocol checker for the normalization back end: latency and result encoding
`timescale 1ns/100ps

module fmac_norm_chk
  import fmac_norm_pkg::*;
#(
  parameter int EXP_W  = fmac_norm_pkg::EXP_W,
  parameter int MANT_W = fmac_norm_pkg::MANT_W
)
(
  input logic              clk,
  input logic              rst_n,
  input logic              in_valid,
  input logic              out_valid,
  input logic [MANT_W-1:0] mant_res,
  input logic [EXP_W-1:0]  exp_res,
  input logic              of_flag,
  input logic              uf_flag,
  input logic              invalid
);

  int unsigned fail_cnt = 0;   // Failed assertions so far

  ////////////////////////////////////////
  // Pipeline timing
  ////////////////////////////////////////

  a_lat_fwd: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> ##2 out_valid)
  else
  begin
    fail_cnt++;
    $error("out_valid missing two cycles after in_valid");
  end

  a_lat_back: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(in_valid, 2))
  else
  begin
    fail_cnt++;
    $error("out_valid without in_valid");
  end

  a_rst: assert property (@(posedge clk) !rst_n |=> !out_valid)
  else
  begin
    fail_cnt++;
    $error("out_valid high after reset");
  end

  ////////////////////////////////////////
  // Result encoding
  ////////////////////////////////////////

  a_nan: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && invalid) |-> (exp_res == '1 && mant_res == MANT_QNAN))
  else
  begin
    fail_cnt++;
    $error("invalid result is not a quiet NaN");
  end

  a_of_uf: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !(of_flag && uf_flag))
  else
  begin
    fail_cnt++;
    $error("overflow and underflow together");
  end

endmodule

bind fmac_norm_top fmac_norm_chk #(.EXP_W(EXP_W), .MANT_W(MANT_W)) u_chk (.*);

// File: tb/tb_vectors.svh
// Directed stimulus and expected results for the normalization back end

// Operand classes {inf_a,inf_b,inf_c, zero_a,zero_b,zero_c, nan_a,nan_b,nan_c}
// Expected flags {sign, of, uf, inexact, invalid}
typedef struct packed {
  logic [SUM_W-1:0]  mant;
  logic [EXP_W+1:0]  exp;
  logic [LZ_W-1:0]   lz;
  logic [8:0]        cls;
  logic              no_one;
  logic              sub_op;
  logic              sign;
  logic [2:0]        mode;       // 0 rne, 1 rtz, 2 rdn, 3 rup
  logic              stk;        // Incoming alignment sticky
  logic [MANT_W-1:0] x_mant;
  logic [EXP_W-1:0]  x_exp;
  logic [4:0]        x_flags;
} vec_t;

vec_t vec_q[$];

task automatic add_row(input logic [SUM_W-1:0] mant, input logic [EXP_W+1:0] exp,
                       input logic [LZ_W-1:0] lz, input logic [8:0] cls,
                       input logic no_one, input logic sub_op, input logic sign,
                       input logic [2:0] mode, input logic stk,
                       input logic [MANT_W-1:0] x_mant, input logic [EXP_W-1:0] x_exp,
                       input logic [4:0] x_flags);
  vec_t v;
  v = '{mant, exp, lz, cls, no_one, sub_op, sign, mode, stk, x_mant, x_exp, x_flags};
  vec_q.push_back(v);
endtask

task automatic load_table();
  // Invalid cases give a positive quiet NaN
  add_row(sum_of(0, 0, 0), 10'd16, 0, 9'b000000100, 0, 0, 1, 0, 0, 23'h400000, 8'hff, 5'b00001);
  add_row(sum_of(0, 0, 0), 10'd16, 0, 9'b000000010, 0, 0, 0, 0, 0, 23'h400000, 8'hff, 5'b00001);
  add_row(sum_of(0, 0, 0), 10'd16, 0, 9'b000000001, 0, 0, 1, 0, 0, 23'h400000, 8'hff, 5'b00001);
  add_row(sum_of(0, 0, 0), 10'd16, 0, 9'b001010000, 0, 0, 0, 0, 0, 23'h400000, 8'hff, 5'b00001);
  add_row(sum_of(0, 0, 0), 10'd16, 0, 9'b010001000, 0, 0, 1, 0, 0, 23'h400000, 8'hff, 5'b00001);
  add_row(sum_of(0, 0, 0), 10'd16, 0, 9'b110000000, 0, 1, 1, 0, 0, 23'h400000, 8'hff, 5'b00001);
  // Infinities
  add_row(sum_of(0, 0, 0), 10'd16, 0, 9'b010000000, 0, 0, 1, 0, 0, 23'h000000, 8'hff, 5'b11000);
  add_row(sum_of(0, 0, 0), 10'd255, 0, 9'b0, 0, 0, 0, 0, 0, 23'h000000, 8'hff, 5'b01000);
  // Normal sums with the top bit set and shifted by the count
  add_row(sum_of(23'h123456, 0, 0), 10'd100, 0, 9'b0, 0, 0, 0, 0, 0, 23'h123456, 8'h64, 5'b0);
  add_row(sum_of(23'h123456, 0, 0) >> 3, 10'd100, 3, 9'b0, 0, 0, 0, 0, 0, 23'h123456, 8'h61, 5'b0);
  // Rounding
  add_row(sum_of(23'h7fffff, 2'b10, 0), 10'd100, 0, 9'b0, 0, 0, 0, 0, 0, 23'h0, 8'h65, 5'b00010);
  add_row(sum_of(23'h000002, 2'b10, 0), 10'd100, 0, 9'b0, 0, 0, 0, 0, 0, 23'h2, 8'h64, 5'b00010);
  add_row(sum_of(23'h000003, 2'b10, 0), 10'd100, 0, 9'b0, 0, 0, 0, 0, 0, 23'h4, 8'h64, 5'b00010);
  add_row(sum_of(23'h000010, 2'b00, 0), 10'd100, 0, 9'b0, 0, 0, 0, 3, 1, 23'h11, 8'h64, 5'b00010);
  add_row(sum_of(23'h000010, 2'b00, 0), 10'd100, 0, 9'b0, 0, 0, 1, 2, 1, 23'h11, 8'h64, 5'b10010);
  add_row(sum_of(23'h000010, 2'b00, 0), 10'd100, 0, 9'b0, 0, 0, 0, 2, 1, 23'h10, 8'h64, 5'b00010);
  add_row(sum_of(23'h000010, 2'b11, 0), 10'd100, 0, 9'b0, 0, 0, 0, 1, 0, 23'h10, 8'h64, 5'b00010);
  add_row(sum_of(23'h000010, 2'b01, 0), 10'd100, 0, 9'b0, 0, 0, 1, 3, 0, 23'h10, 8'h64, 5'b10010);
  add_row(sum_of(23'h000010, 2'b11, 0), 10'd100, 0, 9'b0, 0, 0, 0, 0, 0, 23'h11, 8'h64, 5'b00010);
  // Denormal, flush to zero, exact zero
  add_row(sum_of(0, 0, 0), 10'h3ff, 0, 9'b0, 0, 0, 0, 0, 0, 23'h200000, 8'h00, 5'b00100);
  add_row(sum_of(0, 0, 0), 10'h39c, 0, 9'b0, 0, 0, 1, 0, 0, 23'h0, 8'h00, 5'b10100);
  add_row('0, 10'd5, 0, 9'b0, 1, 0, 1, 0, 0, 23'h0, 8'h00, 5'b10000);
endtask

// File: tb/tb_fmac_norm.sv
// Testbench for the FMA normalization and rounding back end
`timescale 1ns/100ps

module tb_fmac_norm
  import fmac_norm_pkg::*;
();

  localparam int N_RAND = 200;

  logic clk = 1'b0;
  logic rst_n;
  logic in_valid, sign_in, no_one, sub_op, sticky_shift_in, sticky_minus_in;
  logic [SUM_W-1:0] mant_in;
  logic signed [EXP_W+1:0] exp_in;
  logic [LZ_W-1:0] lead_one;
  rnd_mode_t rnd_mode;
  logic inf_a, inf_b, inf_c, zero_a, zero_b, zero_c, nan_a, nan_b, nan_c;
  logic out_valid, sign_res, of_flag, uf_flag, inexact, invalid;
  logic [MANT_W-1:0] mant_res;
  logic [EXP_W-1:0] exp_res;

  function automatic logic [SUM_W-1:0] sum_of(input logic [MANT_W-1:0] frac,
                                               input logic [1:0] g, input logic [47:0] low);
    return {1'b1, frac, g, low};   // Leading one on top with guard and sticky window below
  endfunction

  `include "tb_vectors.svh"

  vec_t      exp_q[$];             // Results in flight
  rnd_mode_t mode_q[$];            // Modes expected at stage one
  vec_t      x;
  int        cycles = 0;
  int        limit  = 1000;

  fmac_norm_top #(.EXP_W(EXP_W), .MANT_W(MANT_W)) DUT (.*);

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic fail_stop();
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_mant(input logic [MANT_W-1:0] xv, input logic [MANT_W-1:0] av);
    if (av !== xv)
    begin
      $display("ERR mant_res expected %h got %h", xv, av);
      fail_stop();
    end
  endtask

  task automatic check_exp(input logic [EXP_W-1:0] xv, input logic [EXP_W-1:0] av);
    if (av !== xv)
    begin
      $display("ERR exp_res expected %h got %h", xv, av);
      fail_stop();
    end
  endtask

  task automatic check_flags(input logic [4:0] xv, input logic [4:0] av);
    if (av !== xv)
    begin
      $display("ERR {sign_res,of_flag,uf_flag,inexact,invalid} expected %h got %h", xv, av);
      fail_stop();
    end
  endtask

  task automatic check_mode(input rnd_mode_t xv, input rnd_mode_t av);
    if (av !== xv)
    begin
      $display("ERR norm_rnd expected %h (%s) got %h", xv, xv.name(), av);
      fail_stop();
    end
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic drive_row(input vec_t v);
    in_valid        = 1'b1;
    mant_in         = v.mant;
    exp_in          = v.exp;
    lead_one        = v.lz;
    {inf_a, inf_b, inf_c, zero_a, zero_b, zero_c, nan_a, nan_b, nan_c} = v.cls;
    no_one          = v.no_one;
    sub_op          = v.sub_op;
    sign_in         = v.sign;
    rnd_mode        = rnd_mode_t'(v.mode);
    sticky_shift_in = v.stk;
    exp_q.push_back(v);
    mode_q.push_back(rnd_mode_t'(v.mode));
  endtask

  // Expected result of a normal operand from the rounding rule
  function automatic vec_t round_model(input vec_t v, input logic [1:0] g, input logic st);
    logic        lost;
    logic        ru;
    logic [24:0] m;
    lost = (|g) | st;
    case (v.mode)
      3'd0:    ru = g[1] & (g[0] | st | v.mant[50]);   // Ties to even
      3'd2:    ru = lost & v.sign;
      3'd3:    ru = lost & ~v.sign;
      default: ru = 1'b0;
    endcase
    m = {1'b0, 1'b1, v.mant[72:50]} + ru;
    v.x_mant  = m[24] ? '0 : m[22:0];                  // Carry renormalizes
    v.x_exp   = v.exp[7:0] + m[24];
    v.x_flags = {v.sign, 2'b00, lost, 1'b0};
    return v;
  endfunction

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    vec_t v;
    logic [1:0] g;
    int smode;
    void'($urandom(32'h40af));
    rst_n = 1'b0;
    in_valid = 1'b0;
    drive_row('0);
    in_valid = 1'b0;
    exp_q.delete();
    mode_q.delete();
    sticky_minus_in = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;
    load_table();
    limit = vec_q.size() + N_RAND + 20;
    foreach (vec_q[i])
    begin
      @(negedge clk) drive_row(vec_q[i]);
    end
    for (int i = 0; i < N_RAND; i++)
    begin
      g       = 2'($urandom_range(0, 3));
      smode   = $urandom_range(0, 3);     // Sticky source: none, low sum bit, alignment, subtract
      v       = '0;
      v.exp   = 10'($urandom_range(1, 253));
      v.sign  = 1'($urandom_range(0, 1));
      v.mode  = 3'($urandom_range(0, 3));
      v.stk   = (smode == 2);
      v.mant  = sum_of(23'($urandom), g, (smode == 1) ? 48'h1 << $urandom_range(0, 47) : '0);
      v = round_model(v, g, smode != 0);
      @(negedge clk)
      begin
        drive_row(v);
        sticky_minus_in = (smode == 3);
      end
    end
    @(negedge clk) in_valid = 1'b0;
    while (exp_q.size() != 0)
      @(negedge clk);
    if (DUT.u_chk.fail_cnt == 0)
    begin
      $display("TEST PASS");
      $finish;
    end
    else
    begin
      $display("TEST FAIL");
      $fatal(1, "errors seen");
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk)
  begin
    if (DUT.u_chk.fail_cnt != 0)
    begin
      $display("A bound assertion in the checker failed");
      fail_stop();
    end
    if (rst_n && DUT.norm_valid)
    begin
      if (mode_q.size() == 0)
      begin
        $display("Stage one produced an item that was never sent");
        fail_stop();
      end
      check_mode(mode_q.pop_front(), DUT.norm_rnd);
    end
    if (rst_n && out_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("out_valid went high with no result pending");
        fail_stop();
      end
      x = exp_q.pop_front();
      check_mant(x.x_mant, mant_res);
      check_exp(x.x_exp, exp_res);
      check_flags(x.x_flags, {sign_res, of_flag, uf_flag, inexact, invalid});
    end
  end

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      cycles++;
      if (cycles > limit)
      begin
        $display("Timeout: out_valid never came for %0d pending results", exp_q.size());
        fail_stop();
      end
    end
  end

endmodule
